// File: source/exe_pkg.sv
package exe_pkg;

	localparam int xlen = 32;
	localparam int reg_addr_w = 5;
	localparam int apb_addr_w = 8;

	typedef logic [xlen-1:0] xlen_t;
	typedef logic [reg_addr_w-1:0] reg_addr_t;
	typedef logic [apb_addr_w-1:0] apb_addr_t;

	typedef enum logic [3:0]
	{
		alu_add  = 4'd0,
		alu_sub  = 4'd1,
		alu_sll  = 4'd2,
		alu_slt  = 4'd3,
		alu_sltu = 4'd4,
		alu_xor  = 4'd5,
		alu_srl  = 4'd6,
		alu_sra  = 4'd7,
		alu_or   = 4'd8,
		alu_and  = 4'd9
	} alu_op_e;

	// Same codes as funct3 of the branch instructions
	typedef enum logic [2:0]
	{
		br_beq  = 3'd0,
		br_bne  = 3'd1,
		br_blt  = 3'd4,
		br_bge  = 3'd5,
		br_bltu = 3'd6,
		br_bgeu = 3'd7
	} br_cond_e;

	typedef enum logic [2:0]
	{
		md_mul    = 3'd0,
		md_mulh   = 3'd1,
		md_mulhsu = 3'd2,
		md_mulhu  = 3'd3,
		md_div    = 3'd4,
		md_divu   = 3'd5,
		md_rem    = 3'd6,
		md_remu   = 3'd7
	} md_op_e;

	// Code 4 stays free for a load result
	typedef enum logic [2:0]
	{
		wb_alu      = 3'd0,
		wb_pc_plus4 = 3'd1,
		wb_muldiv   = 3'd2,
		wb_lui      = 3'd3,
		wb_auipc    = 3'd5
	} wb_sel_e;

	typedef enum logic [1:0]
	{
		ctl_none   = 2'd0,
		ctl_branch = 2'd1,
		ctl_jal    = 2'd2,
		ctl_jalr   = 2'd3
	} ctl_kind_e;

	localparam apb_addr_t csr_ctrl      = 8'h00;	// Bit 0 enables the M extension
	localparam apb_addr_t csr_br_count  = 8'h04;	// Taken control transfers
	localparam apb_addr_t csr_ret_count = 8'h08;	// Retired register writes

endpackage

// File: source/exe_op_if.sv
interface exe_op_if;

	logic                  valid;
	exe_pkg::xlen_t        op_a;
	exe_pkg::xlen_t        op_b;
	exe_pkg::xlen_t        pc;
	exe_pkg::xlen_t        b_imm;
	exe_pkg::xlen_t        j_imm;
	exe_pkg::xlen_t        u_imm;
	exe_pkg::alu_op_e      alu_op;
	exe_pkg::br_cond_e     br_cond;
	exe_pkg::md_op_e       md_op;
	exe_pkg::ctl_kind_e    ctl_kind;
	exe_pkg::wb_sel_e      wb_sel;
	exe_pkg::reg_addr_t    rd;
	logic                  we;

	// Pipe-5 register side
	modport stage (
		output valid, op_a, op_b, pc, b_imm, j_imm, u_imm,
		output alu_op, br_cond, md_op, ctl_kind, wb_sel, rd, we
	);

	// Functional unit side
	modport unit (
		input valid, op_a, op_b, pc, b_imm, j_imm, u_imm,
		input alu_op, br_cond, md_op, ctl_kind, wb_sel, rd, we
	);

endinterface

// File: source/alu.sv
module alu (
	exe_op_if.unit         op,
	output exe_pkg::xlen_t result,
	output logic           cmp_true
);

	logic [4:0] shamt;
	logic       lt_s;
	logic       lt_u;

	assign shamt = op.op_b[4:0];
	assign lt_s  = $signed(op.op_a) < $signed(op.op_b);
	assign lt_u  = op.op_a < op.op_b;

	always_comb
	begin
		case (op.alu_op)
			exe_pkg::alu_add:  result = op.op_a + op.op_b;
			exe_pkg::alu_sub:  result = op.op_a - op.op_b;
			exe_pkg::alu_sll:  result = op.op_a << shamt;
			exe_pkg::alu_slt:  result = {31'b0, lt_s};
			exe_pkg::alu_sltu: result = {31'b0, lt_u};
			exe_pkg::alu_xor:  result = op.op_a ^ op.op_b;
			exe_pkg::alu_srl:  result = op.op_a >> shamt;
			exe_pkg::alu_sra:  result = $signed(op.op_a) >>> shamt;
			exe_pkg::alu_or:   result = op.op_a | op.op_b;
			exe_pkg::alu_and:  result = op.op_a & op.op_b;
			default:           result = '0;
		endcase
	end

	// Branch compare shares the operand path
	always_comb
	begin
		case (op.br_cond)
			exe_pkg::br_beq:  cmp_true = op.op_a == op.op_b;
			exe_pkg::br_bne:  cmp_true = op.op_a != op.op_b;
			exe_pkg::br_blt:  cmp_true = lt_s;
			exe_pkg::br_bge:  cmp_true = !lt_s;
			exe_pkg::br_bltu: cmp_true = lt_u;
			exe_pkg::br_bgeu: cmp_true = !lt_u;
			default:          cmp_true = 1'b0;
		endcase
	end

endmodule

// File: source/branch_unit.sv
module branch_unit (
	exe_op_if.unit         op,
	input  logic           cmp_true,
	output exe_pkg::xlen_t target,
	output logic           taken
);

	exe_pkg::xlen_t jalr_sum;

	assign jalr_sum = op.op_a + op.op_b;	// op_b holds the I immediate

	always_comb
	begin
		case (op.ctl_kind)
			exe_pkg::ctl_branch: target = op.pc + op.b_imm;
			exe_pkg::ctl_jal:    target = op.pc + op.j_imm;
			exe_pkg::ctl_jalr:   target = {jalr_sum[31:1], 1'b0};
			default:             target = op.pc + 32'd4;	// Fall through
		endcase
	end

	always_comb
	begin
		taken = 1'b0;
		if (op.valid)
		begin
			case (op.ctl_kind)
				exe_pkg::ctl_branch: taken = cmp_true;
				exe_pkg::ctl_jal,
				exe_pkg::ctl_jalr:   taken = 1'b1;
				default:             taken = 1'b0;
			endcase
		end
	end

endmodule

// File: source/mul_div.sv
module mul_div (
	exe_op_if.unit         op,
	output exe_pkg::xlen_t result
);

	logic               sign_a;
	logic               sign_b;
	logic signed [65:0] prod;
	logic               div_zero;
	logic               div_ovf;
	exe_pkg::xlen_t     quot_s;
	exe_pkg::xlen_t     rem_s;
	exe_pkg::xlen_t     quot_u;
	exe_pkg::xlen_t     rem_u;

	// Sign extension into a 33-bit operand picks the mulh variant
	assign sign_a = (op.md_op == exe_pkg::md_mulh || op.md_op == exe_pkg::md_mulhsu)
		&& op.op_a[31];
	assign sign_b = (op.md_op == exe_pkg::md_mulh) && op.op_b[31];
	assign prod   = $signed({sign_a, op.op_a}) * $signed({sign_b, op.op_b});

	assign div_zero = op.op_b == '0;
	assign div_ovf  = op.op_a == 32'h8000_0000 && op.op_b == 32'hffff_ffff;

	assign quot_s = $signed(op.op_a) / $signed(op.op_b);
	assign rem_s  = $signed(op.op_a) % $signed(op.op_b);
	assign quot_u = op.op_a / op.op_b;
	assign rem_u  = op.op_a % op.op_b;

	always_comb
	begin
		case (op.md_op)
			exe_pkg::md_mul:    result = prod[31:0];
			exe_pkg::md_mulh,
			exe_pkg::md_mulhsu,
			exe_pkg::md_mulhu:  result = prod[63:32];
			exe_pkg::md_div:
			begin
				if (div_zero)
					result = '1;
				else if (div_ovf)
					result = op.op_a;	// -2^31 / -1
				else
					result = quot_s;
			end
			exe_pkg::md_divu:   result = div_zero ? '1 : quot_u;
			exe_pkg::md_rem:
			begin
				if (div_zero)
					result = op.op_a;
				else if (div_ovf)
					result = '0;
				else
					result = rem_s;
			end
			exe_pkg::md_remu:   result = div_zero ? op.op_a : rem_u;
			default:            result = '0;
		endcase
	end

endmodule

// File: source/exe_csr_apb.sv
module exe_csr_apb (
	input  logic               clk,
	input  logic               nrst,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  exe_pkg::apb_addr_t paddr,
	input  exe_pkg::xlen_t     pwdata,
	output exe_pkg::xlen_t     prdata,
	input  logic               ctl_taken,
	input  logic               retire,
	output logic               muldiv_en
);

	logic           wr_en;
	exe_pkg::xlen_t br_count;
	exe_pkg::xlen_t ret_count;

	// No wait states, access phase always completes
	assign wr_en = psel && penable && pwrite;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			muldiv_en <= 1'b1;
			br_count  <= '0;
			ret_count <= '0;
		end
		else
		begin
			if (wr_en && paddr == exe_pkg::csr_ctrl)
				muldiv_en <= pwdata[0];

			// A write clears the counter, whatever the data
			if (wr_en && paddr == exe_pkg::csr_br_count)
				br_count <= '0;
			else if (ctl_taken)
				br_count <= br_count + 32'd1;

			if (wr_en && paddr == exe_pkg::csr_ret_count)
				ret_count <= '0;
			else if (retire)
				ret_count <= ret_count + 32'd1;
		end
	end

	always_comb
	begin
		case (paddr)
			exe_pkg::csr_ctrl:      prdata = {31'b0, muldiv_en};
			exe_pkg::csr_br_count:  prdata = br_count;
			exe_pkg::csr_ret_count: prdata = ret_count;
			default:                prdata = '0;	// Unmapped
		endcase
	end

endmodule

// File: source/exe_stage.sv
module exe_stage (
	input  logic               clk,
	input  logic               nrst,
	input  logic               issue_valid,
	input  exe_pkg::xlen_t     op_a,
	input  exe_pkg::xlen_t     op_b,
	input  exe_pkg::xlen_t     pc,
	input  exe_pkg::xlen_t     b_imm,
	input  exe_pkg::xlen_t     j_imm,
	input  exe_pkg::xlen_t     u_imm,
	input  exe_pkg::alu_op_e   alu_op,
	input  exe_pkg::br_cond_e  br_cond,
	input  exe_pkg::md_op_e    md_op,
	input  exe_pkg::ctl_kind_e ctl_kind,
	input  exe_pkg::wb_sel_e   wb_sel,
	input  exe_pkg::reg_addr_t rd,
	input  logic               we,
	input  logic               muldiv_en,
	output logic               ctl_taken,
	output logic               retire,
	output exe_pkg::xlen_t     target,
	output logic               redirect,
	output logic               wb_valid,
	output exe_pkg::reg_addr_t wb_rd,
	output logic               wb_we,
	output exe_pkg::xlen_t     wb_data,
	output logic               illegal_op
);

	exe_op_if p5();

	exe_pkg::xlen_t     alu_res5;
	exe_pkg::xlen_t     md_res5;
	logic               cmp_true5;
	logic               taken5;

	logic               valid6;
	logic               we6;
	exe_pkg::reg_addr_t rd6;
	exe_pkg::wb_sel_e   wb_sel6;
	exe_pkg::xlen_t     alu_res6;
	exe_pkg::xlen_t     md_res6;
	exe_pkg::xlen_t     pc6;
	exe_pkg::xlen_t     u_imm6;
	exe_pkg::xlen_t     au_sum6;

	logic               md_blocked6;
	logic               we_out6;
	exe_pkg::xlen_t     wb_mux6;

	// Pipe 5
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			p5.valid <= 1'b0;
		else
			p5.valid <= issue_valid;
	end

	always_ff @(posedge clk)
	begin
		p5.op_a     <= op_a;
		p5.op_b     <= op_b;
		p5.pc       <= pc;
		p5.b_imm    <= b_imm;
		p5.j_imm    <= j_imm;
		p5.u_imm    <= u_imm;
		p5.alu_op   <= alu_op;
		p5.br_cond  <= br_cond;
		p5.md_op    <= md_op;
		p5.ctl_kind <= ctl_kind;
		p5.wb_sel   <= wb_sel;
		p5.rd       <= rd;
		p5.we       <= we;
	end

	alu u_alu (
		.op       (p5),
		.result   (alu_res5),
		.cmp_true (cmp_true5)
	);

	branch_unit u_branch_unit (
		.op       (p5),
		.cmp_true (cmp_true5),
		.target   (target),
		.taken    (taken5)
	);

	mul_div u_mul_div (
		.op     (p5),
		.result (md_res5)
	);

	assign redirect  = taken5;
	assign ctl_taken = taken5;

	// Pipe 6
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			valid6 <= 1'b0;
		else
			valid6 <= p5.valid;
	end

	always_ff @(posedge clk)
	begin
		we6      <= p5.we;
		rd6      <= p5.rd;
		wb_sel6  <= p5.wb_sel;
		alu_res6 <= alu_res5;
		md_res6  <= md_res5;
		pc6      <= p5.pc;
		u_imm6   <= p5.u_imm;
		au_sum6  <= p5.pc + p5.u_imm;
	end

	// M ops are refused while the extension is off
	assign md_blocked6 = wb_sel6 == exe_pkg::wb_muldiv && !muldiv_en;
	assign we_out6     = valid6 && we6 && !md_blocked6;
	assign retire      = we_out6;

	always_comb
	begin
		case (wb_sel6)
			exe_pkg::wb_alu:      wb_mux6 = alu_res6;
			exe_pkg::wb_pc_plus4: wb_mux6 = pc6 + 32'd4;	// Link address
			exe_pkg::wb_muldiv:   wb_mux6 = md_res6;
			exe_pkg::wb_lui:      wb_mux6 = u_imm6;
			exe_pkg::wb_auipc:    wb_mux6 = au_sum6;
			default:              wb_mux6 = '0;
		endcase
	end

	// Write-back outputs
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			wb_valid   <= 1'b0;
			wb_we      <= 1'b0;
			illegal_op <= 1'b0;
		end
		else
		begin
			wb_valid   <= valid6;
			wb_we      <= we_out6;
			illegal_op <= valid6 && md_blocked6;
		end
	end

	always_ff @(posedge clk)
	begin
		wb_rd   <= rd6;
		wb_data <= wb_mux6;
	end

endmodule

// File: source/exe_top.sv
module exe_top (
	input  logic               clk,
	input  logic               nrst,
	input  logic               issue_valid,
	input  exe_pkg::xlen_t     op_a,
	input  exe_pkg::xlen_t     op_b,
	input  exe_pkg::xlen_t     pc,
	input  exe_pkg::xlen_t     b_imm,
	input  exe_pkg::xlen_t     j_imm,
	input  exe_pkg::xlen_t     u_imm,
	input  exe_pkg::alu_op_e   alu_op,
	input  exe_pkg::br_cond_e  br_cond,
	input  exe_pkg::md_op_e    md_op,
	input  exe_pkg::ctl_kind_e ctl_kind,
	input  exe_pkg::wb_sel_e   wb_sel,
	input  exe_pkg::reg_addr_t rd,
	input  logic               we,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  exe_pkg::apb_addr_t paddr,
	input  exe_pkg::xlen_t     pwdata,
	output exe_pkg::xlen_t     prdata,
	output exe_pkg::xlen_t     target,
	output logic               redirect,
	output logic               wb_valid,
	output exe_pkg::reg_addr_t wb_rd,
	output logic               wb_we,
	output exe_pkg::xlen_t     wb_data,
	output logic               illegal_op
);

	logic muldiv_en;
	logic ctl_taken;
	logic retire;

	exe_stage u_exe_stage (
		.clk         (clk),
		.nrst        (nrst),
		.issue_valid (issue_valid),
		.op_a        (op_a),
		.op_b        (op_b),
		.pc          (pc),
		.b_imm       (b_imm),
		.j_imm       (j_imm),
		.u_imm       (u_imm),
		.alu_op      (alu_op),
		.br_cond     (br_cond),
		.md_op       (md_op),
		.ctl_kind    (ctl_kind),
		.wb_sel      (wb_sel),
		.rd          (rd),
		.we          (we),
		.muldiv_en   (muldiv_en),
		.ctl_taken   (ctl_taken),
		.retire      (retire),
		.target      (target),
		.redirect    (redirect),
		.wb_valid    (wb_valid),
		.wb_rd       (wb_rd),
		.wb_we       (wb_we),
		.wb_data     (wb_data),
		.illegal_op  (illegal_op)
	);

	// Control and event counters
	exe_csr_apb u_exe_csr_apb (
		.clk       (clk),
		.nrst      (nrst),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.ctl_taken (ctl_taken),
		.retire    (retire),
		.muldiv_en (muldiv_en)
	);

endmodule

// File: sim/tb_exe_ref.sv
package tb_exe_ref;

	// Fields of one issued operation, as the DUT samples them
	typedef struct packed {
		exe_pkg::xlen_t     op_a;
		exe_pkg::xlen_t     op_b;
		exe_pkg::xlen_t     pc;
		exe_pkg::xlen_t     b_imm;
		exe_pkg::xlen_t     j_imm;
		exe_pkg::xlen_t     u_imm;
		exe_pkg::alu_op_e   alu_op;
		exe_pkg::br_cond_e  br_cond;
		exe_pkg::md_op_e    md_op;
		exe_pkg::ctl_kind_e ctl_kind;
		exe_pkg::wb_sel_e   wb_sel;
		exe_pkg::reg_addr_t rd;
		logic               we;
	} op_t;

	typedef struct packed {
		exe_pkg::xlen_t     data;
		exe_pkg::xlen_t     target;
		logic               taken;
		logic               check_target;	// Only for control transfers
		logic               we;
		logic               illegal;
		exe_pkg::reg_addr_t rd;
	} exp_t;

	function automatic exe_pkg::xlen_t alu_result(exe_pkg::alu_op_e f, exe_pkg::xlen_t a,
		exe_pkg::xlen_t b);
		logic [4:0]     sh;
		exe_pkg::xlen_t r;
		sh = b[4:0];
		case (f)
			exe_pkg::alu_add:  r = a + b;
			exe_pkg::alu_sub:  r = a - b;
			exe_pkg::alu_sll:  r = a << sh;
			exe_pkg::alu_slt:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			exe_pkg::alu_sltu: r = (a < b) ? 32'd1 : 32'd0;
			exe_pkg::alu_xor:  r = a ^ b;
			exe_pkg::alu_srl:  r = a >> sh;
			exe_pkg::alu_sra:  r = $signed(a) >>> sh;
			exe_pkg::alu_or:   r = a | b;
			exe_pkg::alu_and:  r = a & b;
			default:           r = '0;
		endcase
		return r;
	endfunction

	// 64-bit arithmetic, so -2^31 / -1 lands on the RISC-V overflow result by itself
	function automatic exe_pkg::xlen_t muldiv_result(exe_pkg::md_op_e f, exe_pkg::xlen_t a,
		exe_pkg::xlen_t b);
		logic signed [63:0] sa;
		logic signed [63:0] sb;
		logic [63:0]        ua;
		logic [63:0]        ub;
		logic [63:0]        p;
		exe_pkg::xlen_t     r;
		sa = {{32{a[31]}}, a};
		sb = {{32{b[31]}}, b};
		ua = {32'b0, a};
		ub = {32'b0, b};
		p  = '0;
		case (f)
			exe_pkg::md_mul:    p = ua * ub;
			exe_pkg::md_mulh:   p = sa * sb;
			exe_pkg::md_mulhsu: p = sa * $signed(ub);
			exe_pkg::md_mulhu:  p = ua * ub;
			exe_pkg::md_div:
			begin
				if (b == 0)
					p = '1;
				else
					p = sa / sb;	// Signed on both sides
			end
			exe_pkg::md_divu:
			begin
				if (b == 0)
					p = '1;
				else
					p = ua / ub;
			end
			exe_pkg::md_rem:
			begin
				if (b == 0)
					p = ua;
				else
					p = sa % sb;	// Sign follows the dividend
			end
			exe_pkg::md_remu:
			begin
				if (b == 0)
					p = ua;
				else
					p = ua % ub;
			end
			default:            p = '0;
		endcase
		if (f == exe_pkg::md_mul || f[2])
			r = p[31:0];
		else
			r = p[63:32];	// High half for the mulh group
		return r;
	endfunction

	function automatic logic branch_cond_met(exe_pkg::br_cond_e c, exe_pkg::xlen_t a,
		exe_pkg::xlen_t b);
		case (c)
			exe_pkg::br_beq:  return a == b;
			exe_pkg::br_bne:  return a != b;
			exe_pkg::br_blt:  return $signed(a) < $signed(b);
			exe_pkg::br_bge:  return $signed(a) >= $signed(b);
			exe_pkg::br_bltu: return a < b;
			exe_pkg::br_bgeu: return a >= b;
			default:          return 1'b0;
		endcase
	endfunction

	function automatic exp_t expect_op(op_t o, logic md_en);
		exp_t e;
		e.rd           = o.rd;
		e.taken        = 1'b0;
		e.target       = '0;
		e.check_target = 1'b1;
		case (o.ctl_kind)
			exe_pkg::ctl_branch:
			begin
				e.taken  = branch_cond_met(o.br_cond, o.op_a, o.op_b);
				e.target = o.pc + o.b_imm;
			end
			exe_pkg::ctl_jal:
			begin
				e.taken  = 1'b1;
				e.target = o.pc + o.j_imm;
			end
			exe_pkg::ctl_jalr:
			begin
				e.taken  = 1'b1;
				e.target = (o.op_a + o.op_b) & ~32'h1;
			end
			default: e.check_target = 1'b0;
		endcase
		case (o.wb_sel)
			exe_pkg::wb_alu:      e.data = alu_result(o.alu_op, o.op_a, o.op_b);
			exe_pkg::wb_pc_plus4: e.data = o.pc + 32'd4;
			exe_pkg::wb_muldiv:   e.data = muldiv_result(o.md_op, o.op_a, o.op_b);
			exe_pkg::wb_lui:      e.data = o.u_imm;
			exe_pkg::wb_auipc:    e.data = o.pc + o.u_imm;
			default:              e.data = '0;
		endcase
		e.illegal = (o.wb_sel == exe_pkg::wb_muldiv) && !md_en;
		e.we      = o.we && !e.illegal;
		return e;
	endfunction

endpackage

// File: sim/tb_exe_top.sv
module tb_exe_top;

	timeunit 1ns;
	timeprecision 100ps;

	logic               clk;
	logic               nrst;
	logic               issue_valid;
	exe_pkg::xlen_t     op_a;
	exe_pkg::xlen_t     op_b;
	exe_pkg::xlen_t     pc;
	exe_pkg::xlen_t     b_imm;
	exe_pkg::xlen_t     j_imm;
	exe_pkg::xlen_t     u_imm;
	exe_pkg::alu_op_e   alu_op;
	exe_pkg::br_cond_e  br_cond;
	exe_pkg::md_op_e    md_op;
	exe_pkg::ctl_kind_e ctl_kind;
	exe_pkg::wb_sel_e   wb_sel;
	exe_pkg::reg_addr_t rd;
	logic               we;
	logic               psel;
	logic               penable;
	logic               pwrite;
	exe_pkg::apb_addr_t paddr;
	exe_pkg::xlen_t     pwdata;
	exe_pkg::xlen_t     prdata;
	exe_pkg::xlen_t     target;
	logic               redirect;
	logic               wb_valid;
	exe_pkg::reg_addr_t wb_rd;
	logic               wb_we;
	exe_pkg::xlen_t     wb_data;
	logic               illegal_op;

	tb_exe_ref::exp_t   ctl_q[$];
	tb_exe_ref::exp_t   wb_q[$];
	int                 due_q[$];	// Cycle in which each write-back is due
	int                 cycle;
	int                 errors;
	int                 checks;
	int                 test_errors;
	int                 tests_run;
	int                 tests_failed;
	int                 taken_cnt;
	int                 retire_cnt;
	logic               md_enabled;
	string              test_name;
	exe_pkg::br_cond_e  conds[6];

	exe_top u_exe_top (
		.clk         (clk),
		.nrst        (nrst),
		.issue_valid (issue_valid),
		.op_a        (op_a),
		.op_b        (op_b),
		.pc          (pc),
		.b_imm       (b_imm),
		.j_imm       (j_imm),
		.u_imm       (u_imm),
		.alu_op      (alu_op),
		.br_cond     (br_cond),
		.md_op       (md_op),
		.ctl_kind    (ctl_kind),
		.wb_sel      (wb_sel),
		.rd          (rd),
		.we          (we),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.target      (target),
		.redirect    (redirect),
		.wb_valid    (wb_valid),
		.wb_rd       (wb_rd),
		.wb_we       (wb_we),
		.wb_data     (wb_data),
		.illegal_op  (illegal_op)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial
	begin
		#50us;
		$display("Simulation timed out before all tests finished");
		$display("Test failed");
		$finish;
	end

	task automatic report_mismatch(input string name, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		$display("CHECK FAILED %s expected %h actual %h at %0t", name, exp_val, act_val, $time);
		errors++;
	endtask

	// Expectations come from the fields the DUT samples at this edge
	always @(posedge clk)
	begin : monitor
		tb_exe_ref::op_t  o;
		tb_exe_ref::exp_t e;
		cycle++;
		if (nrst && issue_valid)
		begin
			o = {op_a, op_b, pc, b_imm, j_imm, u_imm, alu_op, br_cond, md_op, ctl_kind,
				wb_sel, rd, we};
			e = tb_exe_ref::expect_op(o, md_enabled);
			ctl_q.push_back(e);
			wb_q.push_back(e);
			due_q.push_back(cycle + 2);
			if (e.taken)
				taken_cnt++;
			if (e.we)
				retire_cnt++;
		end
	end

	always @(negedge clk)
	begin : compare
		tb_exe_ref::exp_t c;
		tb_exe_ref::exp_t w;
		if (nrst)
		begin
			if (ctl_q.size() > 0)
			begin
				c = ctl_q.pop_front();
				checks++;
				if (redirect !== c.taken)
					report_mismatch("redirect", c.taken, redirect);
				if (c.check_target && target !== c.target)
					report_mismatch("target", c.target, target);
			end
			else if (redirect !== 1'b0)
				report_mismatch("redirect", 32'h0, redirect);

			if (wb_q.size() > 0 && due_q[0] == cycle)
			begin
				w = wb_q.pop_front();
				due_q.delete(0);
				checks++;
				if (wb_valid !== 1'b1)
					report_mismatch("wb_valid", 32'h1, wb_valid);
				if (wb_rd !== w.rd)
					report_mismatch("wb_rd", w.rd, wb_rd);
				if (wb_we !== w.we)
					report_mismatch("wb_we", w.we, wb_we);
				if (illegal_op !== w.illegal)
					report_mismatch("illegal_op", w.illegal, illegal_op);
				if (!w.illegal && wb_data !== w.data)
					report_mismatch("wb_data", w.data, wb_data);
			end
			else
			begin
				if (wb_valid !== 1'b0)
					report_mismatch("wb_valid", 32'h0, wb_valid);
				if (wb_we !== 1'b0)
					report_mismatch("wb_we", 32'h0, wb_we);
				if (illegal_op !== 1'b0)
					report_mismatch("illegal_op", 32'h0, illegal_op);
			end
		end
	end

	task automatic clear_issue;
		issue_valid = 1'b0;
		op_a        = '0;
		op_b        = '0;
		pc          = '0;
		b_imm       = '0;
		j_imm       = '0;
		u_imm       = '0;
		alu_op      = exe_pkg::alu_add;
		br_cond     = exe_pkg::br_beq;
		md_op       = exe_pkg::md_mul;
		ctl_kind    = exe_pkg::ctl_none;
		wb_sel      = exe_pkg::wb_alu;
		rd          = '0;
		we          = 1'b0;
	endtask

	// Random ALU op, the base for the other kinds
	task automatic drive_alu_op;
		issue_valid = 1'b1;
		op_a        = $urandom;
		op_b        = $urandom;
		pc          = $urandom & 32'hffff_fffc;
		b_imm       = $urandom & 32'hffff_fffe;
		j_imm       = $urandom & 32'hffff_fffe;
		u_imm       = $urandom & 32'hffff_f000;
		alu_op      = exe_pkg::alu_op_e'($urandom_range(0, 9));
		br_cond     = exe_pkg::br_beq;
		md_op       = exe_pkg::md_mul;
		ctl_kind    = exe_pkg::ctl_none;
		wb_sel      = exe_pkg::wb_alu;
		rd          = $urandom_range(0, 31);
		we          = $urandom_range(0, 1);
	endtask

	task automatic drive_ctl_op;
		drive_alu_op();
		if ($urandom_range(0, 3) == 0)
			op_b = op_a;	// Hit the equal case now and then
		case ($urandom_range(0, 3))
			0, 1:
			begin
				ctl_kind = exe_pkg::ctl_branch;
				br_cond  = conds[$urandom_range(0, 5)];
				we       = 1'b0;
			end
			2:
			begin
				ctl_kind = exe_pkg::ctl_jal;
				wb_sel   = exe_pkg::wb_pc_plus4;
				we       = 1'b1;
			end
			default:
			begin
				ctl_kind = exe_pkg::ctl_jalr;
				wb_sel   = exe_pkg::wb_pc_plus4;
				we       = 1'b1;
			end
		endcase
	endtask

	task automatic drive_md_op;
		drive_alu_op();
		md_op  = exe_pkg::md_op_e'($urandom_range(0, 7));
		wb_sel = exe_pkg::wb_muldiv;
		we     = 1'b1;
		if ($urandom_range(0, 3) == 0)
			op_b = $urandom_range(0, 15) - 8;	// Small divisors, zero included
	endtask

	task automatic drive_md_corner(input exe_pkg::md_op_e f, input exe_pkg::xlen_t a,
		input exe_pkg::xlen_t b);
		@(negedge clk);
		drive_md_op();
		md_op = f;
		op_a  = a;
		op_b  = b;
	endtask

	task automatic apb_write(input exe_pkg::apb_addr_t a, input exe_pkg::xlen_t d);
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = a;
		pwdata  = d;
		@(negedge clk);
		penable = 1'b1;
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(input exe_pkg::apb_addr_t a, output exe_pkg::xlen_t d);
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = a;
		@(negedge clk);
		penable = 1'b1;
		@(posedge clk);
		d = prdata;	// End of the access phase
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	// Stop issuing and let the pipe drain
	task automatic wait_idle;
		int n;
		@(negedge clk);
		issue_valid = 1'b0;
		n = 0;
		while (wb_q.size() > 0 && n < 20)
		begin
			@(posedge clk);
			n++;
		end
		if (wb_q.size() > 0)
		begin
			$display("Timed out waiting for %0d pending write-backs", wb_q.size());
			errors++;
		end
	endtask

	task automatic start_test(input string name);
		test_name   = name;
		test_errors = errors;
	endtask

	task automatic finish_test;
		tests_run++;
		if (errors == test_errors)
			$display("[%0d] %s: ok", tests_run, test_name);
		else
		begin
			tests_failed++;
			$display("[%0d] %s: FAILED with %0d errors", tests_run, test_name,
				errors - test_errors);
		end
	endtask

	initial
	begin : main
		exe_pkg::xlen_t rd_val;
		void'($urandom(32'h2afa));
		conds = '{exe_pkg::br_beq, exe_pkg::br_bne, exe_pkg::br_blt, exe_pkg::br_bge,
			exe_pkg::br_bltu, exe_pkg::br_bgeu};
		clear_issue();
		nrst         = 1'b0;
		psel         = 1'b0;
		penable      = 1'b0;
		pwrite       = 1'b0;
		paddr        = '0;
		pwdata       = '0;
		cycle        = 0;
		errors       = 0;
		checks       = 0;
		tests_run    = 0;
		tests_failed = 0;
		taken_cnt    = 0;
		retire_cnt   = 0;
		md_enabled   = 1'b1;
		repeat (4) @(negedge clk);
		nrst = 1'b1;

		start_test("alu ops");
		for (int i = 0; i < 40; i++)
		begin
			@(negedge clk);
			drive_alu_op();
		end
		wait_idle();
		finish_test();

		start_test("pc+4, lui and auipc selects");
		for (int i = 0; i < 30; i++)
		begin
			@(negedge clk);
			drive_alu_op();
			case ($urandom_range(0, 2))
				0:       wb_sel = exe_pkg::wb_pc_plus4;
				1:       wb_sel = exe_pkg::wb_lui;
				default: wb_sel = exe_pkg::wb_auipc;
			endcase
		end
		wait_idle();
		finish_test();

		start_test("branch, jal and jalr");
		for (int i = 0; i < 40; i++)
		begin
			@(negedge clk);
			drive_ctl_op();
		end
		wait_idle();
		finish_test();

		start_test("mul/div with corner cases");
		drive_md_corner(exe_pkg::md_div, 32'h1234_5678, 32'h0);
		drive_md_corner(exe_pkg::md_divu, 32'h8765_4321, 32'h0);
		drive_md_corner(exe_pkg::md_rem, 32'hdead_beef, 32'h0);
		drive_md_corner(exe_pkg::md_remu, 32'h0bad_f00d, 32'h0);
		drive_md_corner(exe_pkg::md_div, 32'h8000_0000, 32'hffff_ffff);
		drive_md_corner(exe_pkg::md_rem, 32'h8000_0000, 32'hffff_ffff);
		drive_md_corner(exe_pkg::md_mulh, 32'h8000_0000, 32'h8000_0000);
		drive_md_corner(exe_pkg::md_mulhsu, 32'hffff_ffff, 32'hffff_ffff);
		for (int i = 0; i < 40; i++)
		begin
			@(negedge clk);
			drive_md_op();
		end
		wait_idle();
		finish_test();

		start_test("M extension disabled");
		apb_write(exe_pkg::csr_ctrl, 32'h0);
		md_enabled = 1'b0;
		apb_read(exe_pkg::csr_ctrl, rd_val);
		checks++;
		if (rd_val !== 32'h0)
			report_mismatch("csr_ctrl", 32'h0, rd_val);
		for (int i = 0; i < 20; i++)
		begin
			@(negedge clk);
			drive_md_op();
		end
		wait_idle();
		apb_write(exe_pkg::csr_ctrl, 32'h1);
		md_enabled = 1'b1;
		for (int i = 0; i < 20; i++)
		begin
			@(negedge clk);
			drive_md_op();
		end
		wait_idle();
		finish_test();

		start_test("event counters");
		apb_write(exe_pkg::csr_br_count, 32'h0);
		apb_write(exe_pkg::csr_ret_count, 32'h0);
		taken_cnt  = 0;
		retire_cnt = 0;
		for (int i = 0; i < 60; i++)
		begin
			@(negedge clk);
			case ($urandom_range(0, 3))
				0:       drive_alu_op();
				1:       drive_ctl_op();
				2:       drive_md_op();
				default: issue_valid = 1'b0;	// Bubble
			endcase
		end
		wait_idle();
		apb_read(exe_pkg::csr_br_count, rd_val);
		checks++;
		if (rd_val !== taken_cnt)
			report_mismatch("csr_br_count", taken_cnt, rd_val);
		apb_read(exe_pkg::csr_ret_count, rd_val);
		checks++;
		if (rd_val !== retire_cnt)
			report_mismatch("csr_ret_count", retire_cnt, rd_val);
		apb_write(exe_pkg::csr_br_count, 32'hffff_ffff);
		apb_write(exe_pkg::csr_ret_count, 32'h1234_5678);
		apb_read(exe_pkg::csr_br_count, rd_val);
		checks++;
		if (rd_val !== 32'h0)
			report_mismatch("csr_br_count", 32'h0, rd_val);
		apb_read(exe_pkg::csr_ret_count, rd_val);
		checks++;
		if (rd_val !== 32'h0)
			report_mismatch("csr_ret_count", 32'h0, rd_val);
		finish_test();

		$display("%0d tests run, %0d failed, %0d checks, %0d errors", tests_run,
			tests_failed, checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: sources.f
source/exe_pkg.sv
source/exe_op_if.sv
source/alu.sv
source/branch_unit.sv
source/mul_div.sv
source/exe_csr_apb.sv
source/exe_stage.sv
source/exe_top.sv
sim/tb_exe_ref.sv
sim/tb_exe_top.sv
